// File: hw/cgra_pod_pkg.sv
package cgra_pod_pkg;

  // ========================================
  // Mesh coordinates and scratchpad words
  // ========================================

  typedef logic [3:0] x_cord_t;
  typedef logic [3:0] y_cord_t;

  // 16-word scratchpad
  typedef logic [3:0] spm_addr_t;

  typedef logic [31:0] word_t;

  // ========================================
  // Request and reply encodings
  // ========================================

  typedef enum logic [1:0] {
    op_load  = 2'd0,
    op_store = 2'd1,
    op_accum = 2'd2
  } req_op_e;

  typedef enum logic {
    rsp_ok        = 1'b0,
    rsp_misrouted = 1'b1
  } rsp_status_e;

  // Forward request, west to east
  typedef struct packed {
    x_cord_t   dst_x;
    y_cord_t   dst_y;
    x_cord_t   src_x;
    y_cord_t   src_y;
    req_op_e   op;
    spm_addr_t addr;
    word_t     data;
  } fwd_pkt_t;

  // Reverse reply, addressed back to the requester
  typedef struct packed {
    x_cord_t     dst_x;
    y_cord_t     dst_y;
    rsp_status_e status;
    word_t       data;
  } rev_pkt_t;

endpackage

// File: hw/io_router_row.sv
module io_router_row (
  input  logic                   mc_clk_i,
  input  logic                   rst_n_i,
  input  cgra_pod_pkg::x_cord_t  my_x_i,
  input  cgra_pod_pkg::y_cord_t  my_y_i,

  // West forward link
  input  cgra_pod_pkg::fwd_pkt_t hor_fwd_i,
  input  logic                   hor_fwd_v_i,
  output logic                   hor_fwd_rdy_o,

  // West reverse link
  output cgra_pod_pkg::rev_pkt_t hor_rev_o,
  output logic                   hor_rev_v_o,
  input  logic                   hor_rev_rdy_i,

  // Processor forward link
  output cgra_pod_pkg::fwd_pkt_t proc_fwd_o,
  output logic                   proc_fwd_v_o,
  input  logic                   proc_fwd_rdy_i,

  // Processor reverse link
  input  cgra_pod_pkg::rev_pkt_t proc_rev_i,
  input  logic                   proc_rev_v_i,
  output logic                   proc_rev_rdy_o
);
  import cgra_pod_pkg::*;

  logic     live_r;
  logic     dst_match;
  logic     err_v_r;
  rev_pkt_t err_pkt_r;
  logic     err_take;
  logic     err_sent;
  logic     rr_r;
  logic     stall_r;
  logic     pick_err_r;
  logic     pick_err;
  logic     rev_fire;

  // Forward path, matching requests pass straight through
  assign dst_match = (hor_fwd_i.dst_x == my_x_i) && (hor_fwd_i.dst_y == my_y_i);

  assign proc_fwd_o    = hor_fwd_i;
  assign proc_fwd_v_o  = live_r & hor_fwd_v_i & dst_match;
  assign err_take      = live_r & hor_fwd_v_i & ~dst_match & ~err_v_r;
  assign hor_fwd_rdy_o = live_r & (dst_match ? proc_fwd_rdy_i : ~err_v_r);

  // Reverse merge, rr_r high gives the processor priority
  // Selection is frozen while a shown reply waits for ready
  assign pick_err = stall_r ? pick_err_r : (err_v_r & (~proc_rev_v_i | ~rr_r));

  assign hor_rev_o      = pick_err ? err_pkt_r : proc_rev_i;
  assign hor_rev_v_o    = pick_err ? err_v_r : proc_rev_v_i;
  assign proc_rev_rdy_o = live_r & hor_rev_rdy_i & ~pick_err;

  assign err_sent = pick_err & hor_rev_rdy_i;
  assign rev_fire = hor_rev_v_o & hor_rev_rdy_i;

  always_ff @(posedge mc_clk_i) begin
    if (!rst_n_i) begin
      live_r     <= 1'b0;
      err_v_r    <= 1'b0;
      rr_r       <= 1'b0;
      stall_r    <= 1'b0;
      pick_err_r <= 1'b0;
    end else begin
      live_r     <= 1'b1;
      stall_r    <= hor_rev_v_o & ~hor_rev_rdy_i;
      pick_err_r <= pick_err;
      if (err_take) begin
        err_v_r <= 1'b1;
      end else if (err_sent) begin
        err_v_r <= 1'b0;
      end
      // Whoever was served yields priority next time
      if (rev_fire) begin
        rr_r <= pick_err;
      end
    end
  end

  // Error reply goes back to the requester with its own data word
  always_ff @(posedge mc_clk_i) begin
    if (err_take) begin
      err_pkt_r.dst_x  <= hor_fwd_i.src_x;
      err_pkt_r.dst_y  <= hor_fwd_i.src_y;
      err_pkt_r.status <= rsp_misrouted;
      err_pkt_r.data   <= hor_fwd_i.data;
    end
  end

endmodule

// File: hw/async_noc_link.sv
module async_noc_link #(
  parameter int width_p        = 32,
  parameter int fifo_lg_size_p = 3
) (
  input  logic               rst_n_i,

  // Write side
  input  logic               wclk_i,
  input  logic [width_p-1:0] w_data_i,
  input  logic               w_v_i,
  output logic               w_rdy_o,

  // Read side
  input  logic               rclk_i,
  output logic [width_p-1:0] r_data_o,
  output logic               r_v_o,
  input  logic               r_rdy_i
);

  localparam int depth_lp = 1 << fifo_lg_size_p;

  logic [width_p-1:0]      mem_r [depth_lp];

  logic [fifo_lg_size_p:0] wbin_r;
  logic [fifo_lg_size_p:0] wbin_next;
  logic [fifo_lg_size_p:0] wgray_r;
  logic [fifo_lg_size_p:0] wgray_next;
  logic [fifo_lg_size_p:0] rgray_w1_r;
  logic [fifo_lg_size_p:0] rgray_w2_r;
  logic                    wfull_r;
  logic                    w_fire;

  logic [fifo_lg_size_p:0] rbin_r;
  logic [fifo_lg_size_p:0] rbin_next;
  logic [fifo_lg_size_p:0] rgray_r;
  logic [fifo_lg_size_p:0] rgray_next;
  logic [fifo_lg_size_p:0] wgray_r1_r;
  logic [fifo_lg_size_p:0] wgray_r2_r;
  logic                    rempty_r;
  logic                    r_fire;

  // ========================================
  // Write domain
  // ========================================

  assign w_rdy_o    = ~wfull_r;
  assign w_fire     = w_v_i & ~wfull_r;
  assign wbin_next  = wbin_r + {{fifo_lg_size_p{1'b0}}, w_fire};
  assign wgray_next = (wbin_next >> 1) ^ wbin_next;

  always_ff @(posedge wclk_i) begin
    if (!rst_n_i) begin
      wbin_r     <= '0;
      wgray_r    <= '0;
      rgray_w1_r <= '0;
      rgray_w2_r <= '0;
      wfull_r    <= 1'b1;  // holds ready low through reset
    end else begin
      wbin_r     <= wbin_next;
      wgray_r    <= wgray_next;
      rgray_w1_r <= rgray_r;
      rgray_w2_r <= rgray_w1_r;
      // Full when the top two Gray bits differ and the rest agree
      wfull_r    <= wgray_next == {~rgray_w2_r[fifo_lg_size_p -: 2],
                                   rgray_w2_r[fifo_lg_size_p-2:0]};
    end
  end

  always_ff @(posedge wclk_i) begin
    if (w_fire) begin
      mem_r[wbin_r[fifo_lg_size_p-1:0]] <= w_data_i;
    end
  end

  // ========================================
  // Read domain
  // ========================================

  assign r_v_o      = ~rempty_r;
  assign r_data_o   = mem_r[rbin_r[fifo_lg_size_p-1:0]];
  assign r_fire     = r_rdy_i & ~rempty_r;
  assign rbin_next  = rbin_r + {{fifo_lg_size_p{1'b0}}, r_fire};
  assign rgray_next = (rbin_next >> 1) ^ rbin_next;

  always_ff @(posedge rclk_i) begin
    if (!rst_n_i) begin
      rbin_r     <= '0;
      rgray_r    <= '0;
      wgray_r1_r <= '0;
      wgray_r2_r <= '0;
      rempty_r   <= 1'b1;
    end else begin
      rbin_r     <= rbin_next;
      rgray_r    <= rgray_next;
      wgray_r1_r <= wgray_r;
      wgray_r2_r <= wgray_r1_r;
      rempty_r   <= rgray_next == wgray_r2_r;
    end
  end

endmodule

// File: hw/xcel_tile.sv
module xcel_tile #(
  parameter int num_rows_p = 2
) (
  input  logic                                    xcel_clk_i,
  input  logic                                    rst_n_i,
  input  cgra_pod_pkg::x_cord_t                   my_x_i,
  input  cgra_pod_pkg::y_cord_t                   my_y_i,

  input  cgra_pod_pkg::fwd_pkt_t [num_rows_p-1:0] link_fwd_i,
  input  logic [num_rows_p-1:0]                   link_fwd_v_i,
  output logic [num_rows_p-1:0]                   link_fwd_rdy_o,

  output cgra_pod_pkg::rev_pkt_t [num_rows_p-1:0] link_rev_o,
  output logic [num_rows_p-1:0]                   link_rev_v_o,
  input  logic [num_rows_p-1:0]                   link_rev_rdy_i
);
  import cgra_pod_pkg::*;

  localparam int row_w_lp     = (num_rows_p > 1) ? $clog2(num_rows_p) : 1;
  localparam int spm_words_lp = 1 << $bits(spm_addr_t);

  word_t                       spm_r [spm_words_lp];
  rev_pkt_t [num_rows_p-1:0]   rev_pkt_r;
  logic [num_rows_p-1:0]       rev_v_r;
  logic [num_rows_p-1:0]       elig;
  logic [row_w_lp-1:0]         last_r;
  logic [row_w_lp-1:0]         gnt_idx;
  logic                        gnt_v;
  fwd_pkt_t                    req;
  word_t                       old_word;
  word_t                       result;
  logic                        req_ok;
  logic                        spm_wr;
  rev_pkt_t                    reply;

  // A row competes only if its reply slot is free or draining now
  assign elig = link_fwd_v_i & (~rev_v_r | link_rev_rdy_i);

  // Round-robin, search starts just after the last winner
  always_comb begin
    int idx;
    gnt_v   = 1'b0;
    gnt_idx = last_r;
    for (int off = num_rows_p; off >= 1; off--) begin
      idx = (int'(last_r) + off) % num_rows_p;
      if (elig[idx]) begin
        gnt_v   = 1'b1;
        gnt_idx = row_w_lp'(idx);
      end
    end
    link_fwd_rdy_o = '0;
    if (gnt_v) begin
      link_fwd_rdy_o[gnt_idx] = 1'b1;
    end
  end

  // ========================================
  // Scratchpad datapath
  // ========================================

  assign req      = link_fwd_i[gnt_idx];
  assign old_word = spm_r[req.addr];
  // Pod rows sit at or below the first row's y
  assign req_ok   = (req.dst_x == my_x_i) && (req.dst_y >= my_y_i);

  always_comb begin
    case (req.op)
      op_store: result = req.data;
      op_accum: result = old_word + req.data;
      default:  result = old_word;
    endcase
  end

  assign spm_wr       = gnt_v & req_ok & (req.op inside {op_store, op_accum});
  assign reply.dst_x  = req.src_x;
  assign reply.dst_y  = req.src_y;
  assign reply.status = req_ok ? rsp_ok : rsp_misrouted;
  assign reply.data   = req_ok ? result : req.data;

  assign link_rev_o   = rev_pkt_r;
  assign link_rev_v_o = rev_v_r;

  always_ff @(posedge xcel_clk_i) begin
    if (!rst_n_i) begin
      last_r  <= row_w_lp'(num_rows_p - 1);
      rev_v_r <= '0;
      for (int a = 0; a < spm_words_lp; a++) begin
        spm_r[a] <= '0;
      end
    end else begin
      if (gnt_v) begin
        last_r <= gnt_idx;
      end
      if (spm_wr) begin
        spm_r[req.addr] <= result;
      end
      for (int r = 0; r < num_rows_p; r++) begin
        if (gnt_v && gnt_idx == row_w_lp'(r)) begin
          rev_v_r[r] <= 1'b1;
        end else if (link_rev_rdy_i[r]) begin
          rev_v_r[r] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge xcel_clk_i) begin
    if (gnt_v) begin
      rev_pkt_r[gnt_idx] <= reply;
    end
  end

endmodule

// File: hw/cgra_pod.sv
module cgra_pod #(
  parameter int num_rows_p     = 2,
  parameter int fifo_lg_size_p = 3
) (
  input  logic                                    xcel_clk_i,
  input  logic                                    mc_clk_i,
  input  logic                                    rst_n_i,

  input  cgra_pod_pkg::fwd_pkt_t [num_rows_p-1:0] mc_fwd_i,
  input  logic [num_rows_p-1:0]                   mc_fwd_v_i,
  output logic [num_rows_p-1:0]                   mc_fwd_rdy_o,

  output cgra_pod_pkg::rev_pkt_t [num_rows_p-1:0] mc_rev_o,
  output logic [num_rows_p-1:0]                   mc_rev_v_o,
  input  logic [num_rows_p-1:0]                   mc_rev_rdy_i,

  input  cgra_pod_pkg::x_cord_t                   global_x_i,
  input  cgra_pod_pkg::y_cord_t [num_rows_p-1:0]  global_y_i
);
  import cgra_pod_pkg::*;

  // Network side of each processor port
  fwd_pkt_t [num_rows_p-1:0] proc_fwd;
  logic [num_rows_p-1:0]     proc_fwd_v;
  logic [num_rows_p-1:0]     proc_fwd_rdy;
  rev_pkt_t [num_rows_p-1:0] proc_rev;
  logic [num_rows_p-1:0]     proc_rev_v;
  logic [num_rows_p-1:0]     proc_rev_rdy;

  // Accelerator side of each processor port
  fwd_pkt_t [num_rows_p-1:0] xcel_fwd;
  logic [num_rows_p-1:0]     xcel_fwd_v;
  logic [num_rows_p-1:0]     xcel_fwd_rdy;
  rev_pkt_t [num_rows_p-1:0] xcel_rev;
  logic [num_rows_p-1:0]     xcel_rev_v;
  logic [num_rows_p-1:0]     xcel_rev_rdy;

  for (genvar i = 0; i < num_rows_p; i++) begin : g_row
    // ========================================
    // Routing
    // ========================================
    io_router_row rtr (
      .mc_clk_i      (mc_clk_i),
      .rst_n_i       (rst_n_i),
      .my_x_i        (global_x_i),
      .my_y_i        (global_y_i[i]),
      .hor_fwd_i     (mc_fwd_i[i]),
      .hor_fwd_v_i   (mc_fwd_v_i[i]),
      .hor_fwd_rdy_o (mc_fwd_rdy_o[i]),
      .hor_rev_o     (mc_rev_o[i]),
      .hor_rev_v_o   (mc_rev_v_o[i]),
      .hor_rev_rdy_i (mc_rev_rdy_i[i]),
      .proc_fwd_o    (proc_fwd[i]),
      .proc_fwd_v_o  (proc_fwd_v[i]),
      .proc_fwd_rdy_i(proc_fwd_rdy[i]),
      .proc_rev_i    (proc_rev[i]),
      .proc_rev_v_i  (proc_rev_v[i]),
      .proc_rev_rdy_o(proc_rev_rdy[i])
    );

    // ========================================
    // Clock-domain crossing
    // ========================================
    async_noc_link #(
      .width_p       ($bits(fwd_pkt_t)),
      .fifo_lg_size_p(fifo_lg_size_p)
    ) fwd (
      .rst_n_i (rst_n_i),
      .wclk_i  (mc_clk_i),
      .w_data_i(proc_fwd[i]),
      .w_v_i   (proc_fwd_v[i]),
      .w_rdy_o (proc_fwd_rdy[i]),
      .rclk_i  (xcel_clk_i),
      .r_data_o(xcel_fwd[i]),
      .r_v_o   (xcel_fwd_v[i]),
      .r_rdy_i (xcel_fwd_rdy[i])
    );

    // Replies head back into the network clock
    async_noc_link #(
      .width_p       ($bits(rev_pkt_t)),
      .fifo_lg_size_p(fifo_lg_size_p)
    ) rev (
      .rst_n_i (rst_n_i),
      .wclk_i  (xcel_clk_i),
      .w_data_i(xcel_rev[i]),
      .w_v_i   (xcel_rev_v[i]),
      .w_rdy_o (xcel_rev_rdy[i]),
      .rclk_i  (mc_clk_i),
      .r_data_o(proc_rev[i]),
      .r_v_o   (proc_rev_v[i]),
      .r_rdy_i (proc_rev_rdy[i])
    );
  end

  // ========================================
  // Accelerator
  // ========================================
  // One tile serves every row, identified by the first row's position
  xcel_tile #(
    .num_rows_p(num_rows_p)
  ) tile (
    .xcel_clk_i    (xcel_clk_i),
    .rst_n_i       (rst_n_i),
    .my_x_i        (global_x_i),
    .my_y_i        (global_y_i[0]),
    .link_fwd_i    (xcel_fwd),
    .link_fwd_v_i  (xcel_fwd_v),
    .link_fwd_rdy_o(xcel_fwd_rdy),
    .link_rev_o    (xcel_rev),
    .link_rev_v_o  (xcel_rev_v),
    .link_rev_rdy_i(xcel_rev_rdy)
  );

endmodule

// File: bench/tb_vectors.svh
// Each entry gives row, dst x, dst y, op, address, data, random data and reply stall cycles
// Pod sits at x 3; row 0 has y 1 and row 1 has y 2

task automatic fill_vectors();
  // Fresh scratchpad reads back zero at every address
  for (int a = 0; a < 16; a++) begin
    add_vec(a % 2, 4'h3, (a % 2 == 1) ? 4'h2 : 4'h1, op_load, spm_addr_t'(a),
            32'h0000_0000, 1'b0, a % 4);
  end

  // Store then load on one row
  add_vec(0, 4'h3, 4'h1, op_store, 4'h2, 32'hcafe_0123, 1'b0, 0);
  add_vec(0, 4'h3, 4'h1, op_load,  4'h2, 32'h0000_0000, 1'b0, 2);

  // Accumulate chain
  add_vec(0, 4'h3, 4'h1, op_store, 4'h7, 32'h0000_0064, 1'b0, 0);
  add_vec(0, 4'h3, 4'h1, op_accum, 4'h7, 32'h0000_0017, 1'b0, 0);
  add_vec(0, 4'h3, 4'h1, op_load,  4'h7, 32'h0000_0000, 1'b0, 0);
  add_vec(1, 4'h3, 4'h2, op_accum, 4'h7, 32'h0000_0000, 1'b1, 1);
  add_vec(0, 4'h3, 4'h1, op_load,  4'h7, 32'h0000_0000, 1'b0, 0);

  // Wrong x, wrong y, then the target word is unchanged
  add_vec(0, 4'h4, 4'h1, op_store, 4'h2, 32'hdead_beef, 1'b0, 0);
  add_vec(1, 4'h3, 4'h1, op_store, 4'h2, 32'h1234_5678, 1'b0, 0);
  add_vec(0, 4'h3, 4'h2, op_accum, 4'h2, 32'h0000_0001, 1'b0, 4);
  add_vec(0, 4'h3, 4'h1, op_load,  4'h2, 32'h0000_0000, 1'b0, 0);

  // Scratchpad is shared by both rows
  add_vec(0, 4'h3, 4'h1, op_store, 4'ha, 32'h0000_0000, 1'b1, 0);
  add_vec(1, 4'h3, 4'h2, op_load,  4'ha, 32'h0000_0000, 1'b0, 0);
  add_vec(1, 4'h3, 4'h2, op_accum, 4'ha, 32'h0000_0000, 1'b1, 0);
  add_vec(0, 4'h3, 4'h1, op_load,  4'ha, 32'h0000_0000, 1'b0, 0);

  // Long reply back-pressure
  add_vec(1, 4'h3, 4'h2, op_store, 4'hc, 32'h0000_0000, 1'b1, 40);
  add_vec(1, 4'h3, 4'h2, op_load,  4'hc, 32'h0000_0000, 1'b0, 60);
  add_vec(0, 4'h5, 4'h7, op_load,  4'hc, 32'h0bad_f00d, 1'b0, 25);
  add_vec(0, 4'h3, 4'h1, op_accum, 4'hc, 32'hffff_ffff, 1'b0, 50);
  add_vec(1, 4'h3, 4'h2, op_load,  4'hc, 32'h0000_0000, 1'b0, 0);
endtask

// File: bench/tb_cgra_pod.sv
module tb_cgra_pod;
  import cgra_pod_pkg::*;

  localparam int      num_rows_lp    = 2;
  localparam int      mc_period_lp   = 40;
  localparam int      xcel_period_lp = 56;
  localparam int      reset_cyc_lp   = 10;
  localparam int      drive_dly_lp   = 2;
  localparam x_cord_t pod_x_lp       = 4'h3;

  // Table entry with where the request goes, what it does and how long replies stall
  typedef struct packed {
    int        row;
    x_cord_t   dst_x;
    y_cord_t   dst_y;
    req_op_e   op;
    spm_addr_t addr;
    word_t     data;
    logic      use_rand;
    int        stall;
  } vec_t;

  logic                        mc_clk;
  logic                        xcel_clk;
  logic                        rst_n;
  fwd_pkt_t [num_rows_lp-1:0]  mc_fwd;
  logic [num_rows_lp-1:0]      mc_fwd_v;
  logic [num_rows_lp-1:0]      mc_fwd_rdy;
  rev_pkt_t [num_rows_lp-1:0]  mc_rev;
  logic [num_rows_lp-1:0]      mc_rev_v;
  logic [num_rows_lp-1:0]      mc_rev_rdy;
  x_cord_t                     global_x;
  y_cord_t [num_rows_lp-1:0]   global_y;

  vec_t   vec_q[$];
  word_t  ref_spm [16];
  integer seed;

  cgra_pod #(
    .num_rows_p    (num_rows_lp),
    .fifo_lg_size_p(3)
  ) dut0 (
    .xcel_clk_i  (xcel_clk),
    .mc_clk_i    (mc_clk),
    .rst_n_i     (rst_n),
    .mc_fwd_i    (mc_fwd),
    .mc_fwd_v_i  (mc_fwd_v),
    .mc_fwd_rdy_o(mc_fwd_rdy),
    .mc_rev_o    (mc_rev),
    .mc_rev_v_o  (mc_rev_v),
    .mc_rev_rdy_i(mc_rev_rdy),
    .global_x_i  (global_x),
    .global_y_i  (global_y)
  );

  // ========================================
  // Clocks and watchdog
  // ========================================

  initial begin
    mc_clk = 1'b0;
    forever #(mc_period_lp / 2) mc_clk = ~mc_clk;
  end

  // Offset so the two clock edges rarely line up
  initial begin
    xcel_clk = 1'b0;
    #5;
    forever #(xcel_period_lp / 2) xcel_clk = ~xcel_clk;
  end

  initial begin
    longint limit;
    #1;
    limit = longint'(reset_cyc_lp + 400 * vec_q.size()) * mc_period_lp;
    #(limit);
    abort_run("Run timed out before every table entry got its reply");
  end

  // ========================================
  // Failure handling and compare tasks
  // ========================================

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_rev(input string name, input rev_pkt_t got, input rev_pkt_t exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_status(input string name, input rsp_status_e got,
                              input rsp_status_e exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
    end
  endtask

  // ========================================
  // Table and reference model
  // ========================================

  task automatic add_vec(input int row, input x_cord_t dst_x, input y_cord_t dst_y,
                         input req_op_e op, input spm_addr_t addr, input word_t data,
                         input logic use_rand, input int stall);
    vec_t v;
    v.row      = row;
    v.dst_x    = dst_x;
    v.dst_y    = dst_y;
    v.op       = op;
    v.addr     = addr;
    v.data     = data;
    v.use_rand = use_rand;
    v.stall    = stall;
    vec_q.push_back(v);
  endtask

  `include "tb_vectors.svh"

  // Expected reply; only a correctly routed request touches the scratchpad
  function automatic rev_pkt_t predict_reply(input fwd_pkt_t req, input int row);
    rev_pkt_t r;
    r.dst_x = req.src_x;
    r.dst_y = req.src_y;
    if (req.dst_x != pod_x_lp || req.dst_y != global_y[row]) begin
      r.status = rsp_misrouted;
      r.data   = req.data;
    end else begin
      r.status = rsp_ok;
      case (req.op)
        op_store: ref_spm[req.addr] = req.data;
        op_accum: ref_spm[req.addr] = ref_spm[req.addr] + req.data;
        default: ;
      endcase
      r.data = ref_spm[req.addr];
    end
    return r;
  endfunction

  // ========================================
  // Link drivers
  // ========================================

  // Called just after a rising edge; returns at the same phase
  task automatic send_request(input int row, input fwd_pkt_t req);
    mc_fwd[row]   = req;
    mc_fwd_v[row] = 1'b1;
    @(negedge mc_clk);
    while (!mc_fwd_rdy[row]) @(negedge mc_clk);
    @(posedge mc_clk);
    #drive_dly_lp;
    mc_fwd_v[row] = 1'b0;
  endtask

  task automatic take_reply(input int row, output rev_pkt_t pkt);
    @(posedge mc_clk);
    #drive_dly_lp;
    mc_rev_rdy[row] = 1'b1;
    @(negedge mc_clk);
    while (!mc_rev_v[row]) @(negedge mc_clk);
    pkt = mc_rev[row];
    @(posedge mc_clk);
    #drive_dly_lp;
    mc_rev_rdy[row] = 1'b0;
  endtask

  task automatic run_vector(input vec_t v);
    fwd_pkt_t req;
    rev_pkt_t exp_rev;
    rev_pkt_t got_rev;
    req.dst_x = v.dst_x;
    req.dst_y = v.dst_y;
    // Requester position varies so the reply address is really checked
    req.src_x = x_cord_t'($random(seed));
    req.src_y = y_cord_t'($random(seed));
    req.op    = v.op;
    req.addr  = v.addr;
    req.data  = v.use_rand ? word_t'($random(seed)) : v.data;
    exp_rev   = predict_reply(req, v.row);
    send_request(v.row, req);
    // Reply ready stays low through the stall
    repeat (v.stall) @(posedge mc_clk);
    take_reply(v.row, got_rev);
    check_status($sformatf("mc_rev_o[%0d].status", v.row), got_rev.status, exp_rev.status);
    check_rev($sformatf("mc_rev_o[%0d]", v.row), got_rev, exp_rev);
  endtask

  initial begin
    seed        = 32'h204f;
    rst_n       = 1'b0;
    mc_fwd      = '0;
    mc_fwd_v    = '0;
    mc_rev_rdy  = '0;
    global_x    = pod_x_lp;
    global_y[0] = 4'h1;
    global_y[1] = 4'h2;
    for (int a = 0; a < 16; a++) begin
      ref_spm[a] = '0;
    end
    fill_vectors();
    repeat (reset_cyc_lp) @(posedge mc_clk);
    #drive_dly_lp;
    rst_n = 1'b1;
    foreach (vec_q[i]) begin
      run_vector(vec_q[i]);
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: flist.f
+incdir+bench
hw/cgra_pod_pkg.sv
hw/io_router_row.sv
hw/async_noc_link.sv
hw/xcel_tile.sv
hw/cgra_pod.sv
bench/tb_cgra_pod.sv

// File: Bender.yml
package:
  name: cgra_pod

sources:
  - files:
      - hw/cgra_pod_pkg.sv
      - hw/io_router_row.sv
      - hw/async_noc_link.sv
      - hw/xcel_tile.sv
      - hw/cgra_pod.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_cgra_pod.sv
